// ==== design/memStagePkg.sv ====
package memStagePkg;

    // two slots per issue group
    localparam int ISSUE_WIDTH = 2;
    localparam int WORD_WIDTH = 32;
    // register file index width
    localparam int REG_ADDR_WIDTH = 5;
    localparam int STROBE_WIDTH = WORD_WIDTH / 8;

    typedef logic [WORD_WIDTH-1:0] wordT;
    typedef logic [STROBE_WIDTH-1:0] strobeT;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;

    // access size, as encoded by decode
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2
    } msizeT;

    // cp0 action carried by a slot
    typedef enum logic [1:0] {
        CP0_NONE = 2'd0,
        CP0_EXCEPTION = 2'd1,
        CP0_ERET = 2'd2
    } cp0TypeT;

    // control bits the memory stage cares about
    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memWrite;
        logic signedLoad;
        msizeT msize;
    } ctlT;

    // one slot coming out of execute
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rdst;
        // effective address for loads and stores
        wordT aluOut;
        // raw store data before lane shift
        wordT srcb;
        ctlT ctl;
        cp0TypeT cp0Type;
    } execDataT;

    // data bus request for one slot
    typedef struct packed {
        logic valid;
        wordT addr;
        msizeT size;
        // all zero on loads
        strobeT strobe;
        wordT data;
    } dbusReqT;

    // writeback slot
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rdst;
        logic regWrite;
        wordT wdata;
    } memResultT;

    // apb master outputs
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        wordT paddr;
        wordT pwdata;
        strobeT pstrb;
    } apbReqT;

    // apb slave outputs, no pslverr
    typedef struct packed {
        logic pready;
        wordT prdata;
    } apbRspT;

endpackage

// ==== design/execMemReg.sv ====
module execMemReg (
    input logic clk,
    input logic rstN,
    input logic inValid,
    output logic inReady,
    input memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE,
    input logic done,
    output logic regValid,
    output memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] regData
);

    // set while a pair sits in the register
    logic occupied;
    logic accept;

    // free slot, or the held pair retires this cycle
    assign inReady = !occupied || done;
    assign accept = inValid && inReady;

    // occupancy flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupied <= 1'b0;
        end else if (accept) begin
            // back-to-back pair on the retire edge keeps it set
            occupied <= 1'b1;
        end else if (done) begin
            occupied <= 1'b0;
        end
    end

    // payload only moves on accept
    // held unchanged while the bus side works on it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regData <= '0;
        end else if (accept) begin
            regData <= dataE;
        end
    end

    // valid one cycle after the accepting edge
    assign regValid = occupied;

endmodule

// ==== design/storeAlign.sv ====
module storeAlign (
    input logic [1:0] addrLow,
    input memStagePkg::wordT storeData,
    input memStagePkg::msizeT size,
    output memStagePkg::wordT alignedData,
    output memStagePkg::strobeT strobe
);

    always_comb begin
        unique case (size)
            memStagePkg::MSIZE1: begin
                // low byte copied to every lane
                alignedData = {4{storeData[7:0]}};
                // one-hot at the addressed byte
                strobe = memStagePkg::strobeT'(4'b0001 << addrLow);
            end
            memStagePkg::MSIZE2: begin
                // low half in both halves
                alignedData = {2{storeData[15:0]}};
                // bit 0 is assumed clear here
                strobe = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                // full word, no shift
                alignedData = storeData;
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

// ==== design/memAccess.sv ====
module memAccess (
    input memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE,
    output memStagePkg::dbusReqT [memStagePkg::ISSUE_WIDTH-1:0] dreq,
    output memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE2,
    output logic excpM
);

    memStagePkg::wordT [memStagePkg::ISSUE_WIDTH-1:0] alignedData;
    memStagePkg::strobeT [memStagePkg::ISSUE_WIDTH-1:0] strobe;
    // exception or eret flagged on the slot itself
    logic [memStagePkg::ISSUE_WIDTH-1:0] ownExcp;
    // slot 1 is the older instruction
    logic olderExcp;

    for (genvar i = 0; i < memStagePkg::ISSUE_WIDTH; i++) begin : gSlot
        // lane shift and byte enables for this slot's store
        storeAlign u_storeAlign (
            .addrLow(dataE[i].aluOut[1:0]),
            .storeData(dataE[i].srcb),
            .size(dataE[i].ctl.msize),
            .alignedData(alignedData[i]),
            .strobe(strobe[i])
        );

        assign ownExcp[i] = dataE[i].valid
            && (dataE[i].cp0Type == memStagePkg::CP0_EXCEPTION
            || dataE[i].cp0Type == memStagePkg::CP0_ERET);
    end

    assign olderExcp = ownExcp[1];

    // squash the younger slot behind an older exception or eret
    always_comb begin
        dataE2 = dataE;
        if (olderExcp) begin
            dataE2[0].ctl.regWrite = 1'b0;
            dataE2[0].ctl.memToReg = 1'b0;
            dataE2[0].ctl.memWrite = 1'b0;
        end
    end

    // requests follow the squashed controls
    for (genvar i = 0; i < memStagePkg::ISSUE_WIDTH; i++) begin : gReq
        always_comb begin
            dreq[i] = '0;
            dreq[i].addr = dataE2[i].aluOut;
            dreq[i].size = dataE2[i].ctl.msize;
            if (dataE2[i].valid && !ownExcp[i]) begin
                if (dataE2[i].ctl.memWrite) begin
                    // store with shifted data and byte enables
                    dreq[i].valid = 1'b1;
                    dreq[i].data = alignedData[i];
                    dreq[i].strobe = strobe[i];
                end else if (dataE2[i].ctl.memToReg) begin
                    // load, strobe stays zero
                    dreq[i].valid = 1'b1;
                end
            end
        end
    end

    // either slot trapping or returning
    assign excpM = |ownExcp;

endmodule

// ==== design/apbDataMaster.sv ====
module apbDataMaster (
    input logic clk,
    input logic rstN,
    input logic regValid,
    input memStagePkg::dbusReqT [memStagePkg::ISSUE_WIDTH-1:0] dreq,
    input memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE2,
    output memStagePkg::apbReqT apbReq,
    input memStagePkg::apbRspT apbRsp,
    output logic done,
    output logic wbValid,
    output memStagePkg::memResultT [memStagePkg::ISSUE_WIDTH-1:0] wb
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_FINISH
    } stateT;

    stateT state;
    stateT stateNext;
    // slot currently on the bus
    logic curSlot;
    logic curSlotNext;
    logic xferDone;
    // raw read words per slot
    memStagePkg::wordT [memStagePkg::ISSUE_WIDTH-1:0] rdata;

    // pick the addressed byte or half and extend it
    function automatic memStagePkg::wordT extendLoad(
        input memStagePkg::wordT raw,
        input logic [1:0] addrLow,
        input memStagePkg::msizeT size,
        input logic signedLoad
    );
        logic [7:0] byteVal;
        logic [15:0] halfVal;
        memStagePkg::wordT result;
        byteVal = raw[8*addrLow +: 8];
        halfVal = addrLow[1] ? raw[31:16] : raw[15:0];
        case (size)
            memStagePkg::MSIZE1: result = {{24{signedLoad & byteVal[7]}}, byteVal};
            memStagePkg::MSIZE2: result = {{16{signedLoad & halfVal[15]}}, halfVal};
            default: result = raw;
        endcase
        return result;
    endfunction

    // access phase ends on pready
    assign xferDone = (state == ST_ACCESS) && apbRsp.pready;

    always_comb begin
        stateNext = state;
        curSlotNext = curSlot;
        unique case (state)
            ST_IDLE: begin
                if (regValid) begin
                    // older slot goes first
                    if (dreq[1].valid) begin
                        stateNext = ST_SETUP;
                        curSlotNext = 1'b1;
                    end else if (dreq[0].valid) begin
                        stateNext = ST_SETUP;
                        curSlotNext = 1'b0;
                    end else begin
                        // nothing for the bus
                        stateNext = ST_FINISH;
                    end
                end
            end
            ST_SETUP: stateNext = ST_ACCESS;
            ST_ACCESS: begin
                if (xferDone) begin
                    if (curSlot && dreq[0].valid) begin
                        stateNext = ST_SETUP;
                        curSlotNext = 1'b0;
                    end else begin
                        stateNext = ST_FINISH;
                    end
                end
            end
            default: stateNext = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
            curSlot <= 1'b0;
        end else begin
            state <= stateNext;
            curSlot <= curSlotNext;
        end
    end

    // read data captured on the completing cycle
    always_ff @(posedge clk) begin
        if (xferDone) begin
            rdata[curSlot] <= apbRsp.prdata;
        end
    end

    // request fields come straight from the held pair
    always_comb begin
        apbReq.psel = (state == ST_SETUP) || (state == ST_ACCESS);
        apbReq.penable = (state == ST_ACCESS);
        apbReq.pwrite = dataE2[curSlot].ctl.memWrite;
        // word address, lanes picked by pstrb
        apbReq.paddr = {dreq[curSlot].addr[31:2], 2'b00};
        apbReq.pwdata = dreq[curSlot].data;
        apbReq.pstrb = dreq[curSlot].strobe;
    end

    // one cycle pulse, also frees the input register
    assign done = (state == ST_FINISH);
    assign wbValid = (state == ST_FINISH);

    for (genvar i = 0; i < memStagePkg::ISSUE_WIDTH; i++) begin : gWb
        always_comb begin
            wb[i].valid = dataE2[i].valid;
            wb[i].pc = dataE2[i].pc;
            wb[i].rdst = dataE2[i].rdst;
            // already cleared for a squashed slot
            wb[i].regWrite = dataE2[i].ctl.regWrite;
            if (dataE2[i].ctl.memToReg) begin
                wb[i].wdata = extendLoad(rdata[i], dreq[i].addr[1:0],
                    dreq[i].size, dataE2[i].ctl.signedLoad);
            end else begin
                wb[i].wdata = dataE2[i].aluOut;
            end
        end
    end

endmodule

// ==== design/memStage.sv ====
module memStage (
    input logic clk,
    input logic rstN,
    input logic inValid,
    output logic inReady,
    input memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE,
    output memStagePkg::apbReqT apbReq,
    input memStagePkg::apbRspT apbRsp,
    output logic excpM,
    output logic wbValid,
    output memStagePkg::memResultT [memStagePkg::ISSUE_WIDTH-1:0] wb
);

    logic regValid;
    logic done;
    memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] regData;
    // pair after slot 0 squash
    memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] dataE2;
    memStagePkg::dbusReqT [memStagePkg::ISSUE_WIDTH-1:0] dreq;

    // input side
    execMemReg u_execMemReg (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inReady(inReady),
        .dataE(dataE),
        .done(done),
        .regValid(regValid),
        .regData(regData)
    );

    // request build, no state
    memAccess u_memAccess (
        .dataE(regData),
        .dreq(dreq),
        .dataE2(dataE2),
        .excpM(excpM)
    );

    // bus side and writeback
    apbDataMaster u_apbDataMaster (
        .clk(clk),
        .rstN(rstN),
        .regValid(regValid),
        .dreq(dreq),
        .dataE2(dataE2),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .done(done),
        .wbValid(wbValid),
        .wb(wb)
    );

endmodule

// ==== tb/apbSlaveModel.sv ====
module apbSlaveModel (
    input logic clk,
    input logic rstN,
    input memStagePkg::apbReqT apbReq,
    output memStagePkg::apbRspT apbRsp
);

    localparam int DEPTH = 64;

    memStagePkg::wordT mem [DEPTH];
    // wait states left in the current access phase
    logic [1:0] waitLeft;
    logic [5:0] idx;

    // word index, low two bits dropped
    assign idx = apbReq.paddr[7:2];

    // fill from the full byte address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (i * 4) * 32'h0100_0193 ^ 32'h5a5a_c3c3;
        end
    end

    // new wait count drawn in the setup cycle
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitLeft <= 2'd0;
        end else if (apbReq.psel && !apbReq.penable) begin
            waitLeft <= 2'($urandom_range(3, 0));
        end else if (apbReq.psel && waitLeft != 2'd0) begin
            waitLeft <= waitLeft - 2'd1;
        end
    end

    always_comb begin
        apbRsp.pready = apbReq.psel && apbReq.penable && (waitLeft == 2'd0);
        apbRsp.prdata = mem[idx];
    end

    // byte lanes written on the completing cycle
    always @(posedge clk) begin
        if (apbRsp.pready && apbReq.pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (apbReq.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apbReq.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== tb/memStageTb.sv ====
module memStageTb;

    localparam int NUM_PAIRS = 400;
    localparam int RESET_CYCLES = 16;
    // worst pair: idle, two runs of setup plus four access cycles, finish
    localparam int CYCLES_PER_PAIR = 12;
    localparam int DRAIN_CYCLES = 20;
    localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_PAIRS * CYCLES_PER_PAIR + 2 * DRAIN_CYCLES;

    typedef memStagePkg::execDataT [memStagePkg::ISSUE_WIDTH-1:0] execPairT;
    typedef memStagePkg::memResultT [memStagePkg::ISSUE_WIDTH-1:0] wbPairT;

    logic clk;
    logic rstN;
    logic inValid;
    logic inReady;
    execPairT dataE;
    memStagePkg::apbReqT apbReq;
    memStagePkg::apbRspT apbRsp;
    logic excpM;
    logic wbValid;
    wbPairT wb;

    // reference copy of the slave memory
    memStagePkg::wordT modelMem [64];
    // expected results, one entry per accepted pair
    wbPairT expWb [$];
    logic expExcp [$];
    int expXfers [$];
    int xferCount;
    int cycleCount;
    int pairsChecked;
    // bus state seen at the previous falling edge
    memStagePkg::apbReqT prevReq;
    logic prevReady;
    memStagePkg::apbReqT expReq;

    memStage u_dut (.*);
    apbSlaveModel u_apbSlave (.*);

    always #20 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWb(input string name, input memStagePkg::memResultT actual,
        input memStagePkg::memResultT expected);
        if (actual !== expected) begin
            failRun($sformatf("ERR t=%0t %s got %h expected %h", $time, name, actual, expected));
        end
    endtask

    task automatic checkExcp(input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("ERR t=%0t excpM got %b expected %b", $time, actual, expected));
        end
    endtask

    task automatic checkXfers(input int actual, input int expected);
        if (actual != expected) begin
            failRun($sformatf("ERR t=%0t apb transfers got %0d expected %0d",
                $time, actual, expected));
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("ERR t=%0t %s got %b expected %b", $time, name, actual, expected));
        end
    endtask

    task automatic checkApbReq(input memStagePkg::apbReqT actual,
        input memStagePkg::apbReqT expected);
        if (actual !== expected) begin
            failRun($sformatf("ERR t=%0t apbReq got %h expected %h",
                $time, actual, expected));
        end
    endtask

    // shift the addressed lane down, then extend
    function automatic memStagePkg::wordT loadModel(input memStagePkg::execDataT s);
        memStagePkg::wordT w;
        w = modelMem[s.aluOut[7:2]] >> (8 * s.aluOut[1:0]);
        if (s.ctl.msize == memStagePkg::MSIZE1) begin
            w = s.ctl.signedLoad ? 32'($signed(w[7:0])) : {24'h0, w[7:0]};
        end else if (s.ctl.msize == memStagePkg::MSIZE2) begin
            w = s.ctl.signedLoad ? 32'($signed(w[15:0])) : {16'h0, w[15:0]};
        end
        return w;
    endfunction

    task automatic storeModel(input memStagePkg::execDataT s);
        int idx;
        int lane;
        idx = s.aluOut[7:2];
        lane = s.aluOut[1:0];
        case (s.ctl.msize)
            memStagePkg::MSIZE1: modelMem[idx][8*lane +: 8] = s.srcb[7:0];
            memStagePkg::MSIZE2: modelMem[idx][8*lane +: 16] = s.srcb[15:0];
            default: modelMem[idx] = s.srcb;
        endcase
    endtask

    // slot 1 is older, so its memory effect lands first
    task automatic modelPair(input execPairT p);
        wbPairT expPair;
        logic [1:0] own;
        logic squash;
        logic live;
        int xfers;
        xfers = 0;
        for (int i = 0; i < 2; i++) begin
            own[i] = p[i].valid && p[i].cp0Type != memStagePkg::CP0_NONE;
        end
        for (int i = 1; i >= 0; i--) begin
            squash = (i == 0) && own[1];
            live = p[i].valid && !own[i] && !squash;
            expPair[i].valid = p[i].valid;
            expPair[i].pc = p[i].pc;
            expPair[i].rdst = p[i].rdst;
            expPair[i].regWrite = p[i].ctl.regWrite && !squash;
            expPair[i].wdata = p[i].aluOut;
            if (live && p[i].ctl.memWrite) begin
                storeModel(p[i]);
                xfers++;
            end else if (live && p[i].ctl.memToReg) begin
                expPair[i].wdata = loadModel(p[i]);
                xfers++;
            end
        end
        expWb.push_back(expPair);
        expExcp.push_back(|own);
        expXfers.push_back(xfers);
    endtask

    // kind 0 alu, 1 load, 2 store, 3 exception or eret, 4 empty slot
    function automatic memStagePkg::execDataT makeSlot(input int kind);
        memStagePkg::execDataT s;
        s = '0;
        s.valid = (kind != 4);
        s.pc = $urandom & 32'hffff_fffc;
        s.rdst = 5'($urandom);
        s.srcb = $urandom;
        s.aluOut = $urandom;
        s.ctl.msize = memStagePkg::MSIZE4;
        if (kind == 1 || kind == 2) begin
            s.ctl.msize = memStagePkg::msizeT'($urandom_range(2, 0));
            // aligned, low 128 bytes so addresses repeat often
            s.aluOut = $urandom_range(127, 0) & ~((32'd1 << s.ctl.msize) - 32'd1);
            s.ctl.memToReg = (kind == 1);
            s.ctl.memWrite = (kind == 2);
            s.ctl.regWrite = (kind == 1);
            s.ctl.signedLoad = 1'($urandom);
        end else if (kind != 4) begin
            s.ctl.regWrite = ($urandom_range(3, 0) != 0);
        end
        if (kind == 3) begin
            s.cp0Type = $urandom_range(1, 0) ? memStagePkg::CP0_ERET : memStagePkg::CP0_EXCEPTION;
        end
        return s;
    endfunction

    function automatic execPairT makePair();
        execPairT p;
        int pick;
        pick = $urandom_range(99, 0);
        p[1] = makeSlot(pick < 12 ? 3 : $urandom_range(2, 0));
        p[0] = makeSlot(pick >= 95 ? 4 : (pick >= 90 ? 3 : $urandom_range(2, 0)));
        // store in slot 1, load of the same word in slot 0
        if (pick >= 80 && pick < 90) begin
            p[1] = makeSlot(2);
            p[0] = makeSlot(1);
            p[0].aluOut[31:2] = p[1].aluOut[31:2];
        end
        return p;
    endfunction

    // inReady only moves on a clock edge, so the falling edge is a safe look
    task automatic waitForAccept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = inReady;
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        execPairT pair;
        int gap;
        void'($urandom(32'h8808));
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        dataE = '0;
        xferCount = 0;
        cycleCount = 0;
        pairsChecked = 0;
        for (int i = 0; i < 64; i++) begin
            modelMem[i] = (i * 4) * 32'h0100_0193 ^ 32'h5a5a_c3c3;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        // idle outputs while in reset
        @(negedge clk);
        checkBit("inReady", inReady, 1'b1);
        checkBit("psel", apbReq.psel, 1'b0);
        checkBit("penable", apbReq.penable, 1'b0);
        checkBit("wbValid", wbValid, 1'b0);
        checkExcp(excpM, 1'b0);
        @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int n = 0; n < NUM_PAIRS; n++) begin
            pair = makePair();
            inValid = 1'b1;
            dataE = pair;
            waitForAccept();
            modelPair(pair);
            inValid = 1'b0;
            // one idle cycle at most, still inside the in-flight pair
            gap = $urandom_range(1, 0);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (pairsChecked == NUM_PAIRS && expWb.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            failRun($sformatf("only %0d of %0d pairs wrote back", pairsChecked, NUM_PAIRS));
        end
    end

    // outputs settled mid-cycle
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            // access follows a setup or a wait, request held until pready
            if (apbReq.penable) begin
                if (!prevReq.psel || (prevReq.penable && prevReady)) begin
                    failRun("apb access phase started without a setup phase before it");
                end
                expReq = prevReq;
                expReq.penable = 1'b1;
                checkApbReq(apbReq, expReq);
            end
            if (apbReq.psel && !apbReq.penable && prevReq.penable && !prevReady) begin
                failRun("apb transfer abandoned before pready");
            end
            if (apbReq.psel && apbReq.penable && apbRsp.pready) begin
                xferCount++;
            end
            if (wbValid) begin
                if (expWb.size() == 0) begin
                    failRun("writeback pulse with no pair outstanding");
                end else begin
                    checkWb("wb[1]", wb[1], expWb[0][1]);
                    checkWb("wb[0]", wb[0], expWb[0][0]);
                    checkExcp(excpM, expExcp[0]);
                    checkXfers(xferCount, expXfers[0]);
                    void'(expWb.pop_front());
                    void'(expExcp.pop_front());
                    void'(expXfers.pop_front());
                    xferCount = 0;
                    pairsChecked++;
                end
            end
        end
        prevReq = apbReq;
        prevReady = apbRsp.pready;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            failRun($sformatf("timeout, run still going after %0d cycles", CYCLE_LIMIT));
        end
    end

endmodule

// ==== files.f ====
design/memStagePkg.sv
design/execMemReg.sv
design/storeAlign.sv
design/memAccess.sv
design/apbDataMaster.sv
design/memStage.sv
tb/apbSlaveModel.sv
tb/memStageTb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # package first, then the stage from the leaves up
  - design/memStagePkg.sv
  - design/execMemReg.sv
  - design/storeAlign.sv
  - design/memAccess.sv
  - design/apbDataMaster.sv
  - design/memStage.sv
  - target: test
    files:
      - tb/apbSlaveModel.sv
      - tb/memStageTb.sv
